// ==== rtl/board_pkg.sv ====
package board_pkg;

    // camera reset hold after core reset release, in core_clk cycles
    localparam logic [31:0] RESET_HOLD_CYCLES = 32'd10000;

    // led toggle threshold, shortened so simulation can see several periods
    localparam logic [31:0] HEARTBEAT_CYCLES  = 32'd2000;

    localparam int          HB_CNT_W          = 16;  // heartbeat counter width

endpackage

// ==== rtl/video_pkg.sv ====
package video_pkg;

    localparam int CAM_BYTE_W = 8;   // sensor parallel bus
    localparam int PIX565_W   = 16;
    localparam int PIX888_W   = 24;
    localparam int LANE888_W  = 8;   // one colour lane of rgb888

    // rgb565 field widths
    localparam int R565_W     = 5;
    localparam int G565_W     = 6;
    localparam int B565_W     = 5;

    // rgb565 field positions, red on top
    localparam int B565_LSB   = 0;
    localparam int G565_LSB   = B565_LSB + B565_W;
    localparam int R565_LSB   = G565_LSB + G565_W;

    localparam int NUM_CAMS   = 2;   // camera inputs on the board

    typedef logic [CAM_BYTE_W-1:0] cam_byte_t;
    typedef logic [PIX565_W-1:0]   rgb565_t;
    typedef logic [PIX888_W-1:0]   rgb888_t;

endpackage

// ==== rtl/power_on_reset.sv ====
`timescale 1ns/10ps

module power_on_reset
    import board_pkg::*;
(
    input  logic core_clk,
    input  logic rst_i,
    output logic cam_rstn_o     // low keeps both sensors in reset
);

    logic [31:0] hold_cnt;
    logic        hold_done;

    assign hold_done = (hold_cnt == RESET_HOLD_CYCLES);

    // saturating delay counter
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 32'd1;
        end
    end

    // registered reached flag, sticky until the next core reset
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            cam_rstn_o <= 1'b0;
        end else if (hold_done) begin
            cam_rstn_o <= 1'b1;
        end
    end

endmodule

// ==== rtl/cmos_pixel_pack.sv ====
`timescale 1ns/10ps

module cmos_pixel_pack
    import video_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_i,
    input  logic      cam_rstn_i,     // sensor out of reset
    input  cam_byte_t cam_data_i,
    input  logic      cam_href_i,
    input  logic      cam_vsync_i,
    output rgb565_t   pix_o,
    output logic      pix_valid_o,    // one cycle per assembled pixel
    output logic      vsync_o
);

    cam_byte_t data_q;
    logic      href_q;
    logic      vsync_q;
    logic      byte_phase;            // set once the high byte is held
    cam_byte_t hi_byte;
    rgb565_t   pix_raw;

    // input capture register
    always_ff @(posedge core_clk) begin
        data_q <= cam_data_i;
    end

    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            href_q  <= cam_href_i;
            vsync_q <= cam_vsync_i;
        end
    end

    assign pix_raw = {hi_byte, data_q};   // high byte arrives first

    // byte phase, restarted by every low href
    always_ff @(posedge core_clk) begin
        if (rst_i || !cam_rstn_i) begin
            byte_phase  <= 1'b0;
            pix_valid_o <= 1'b0;
        end else begin
            pix_valid_o <= 1'b0;
            if (!href_q) begin
                byte_phase <= 1'b0;        // drops a lone trailing byte
            end else begin
                byte_phase  <= ~byte_phase;
                pix_valid_o <= byte_phase;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (href_q && !byte_phase) begin
            hi_byte <= data_q;
        end
        if (href_q && byte_phase) begin
            // sensor sends the colour fields in reverse order, swap outer fields
            pix_o <= {pix_raw[B565_LSB +: B565_W],
                      pix_raw[G565_LSB +: G565_W],
                      pix_raw[R565_LSB +: R565_W]};
        end
    end

    assign vsync_o = vsync_q;

endmodule

// ==== rtl/video_out_mux.sv ====
`timescale 1ns/10ps

module video_out_mux
    import video_pkg::*;
(
    input  logic    core_clk,
    input  logic    rst_i,
    input  logic    sel_i,        // 0 camera 1, 1 camera 2
    input  rgb565_t pix1_i,
    input  rgb565_t pix2_i,
    input  logic    valid1_i,
    input  logic    valid2_i,
    input  logic    vsync1_i,
    input  logic    vsync2_i,
    output rgb888_t rgb_o,
    output logic    de_o,
    output logic    vs_o
);

    rgb565_t             pix_arr [NUM_CAMS];
    logic [NUM_CAMS-1:0] valid_vec;
    logic [NUM_CAMS-1:0] vsync_vec;
    rgb565_t             pix_sel;
    logic [R565_W-1:0]   red5;
    logic [G565_W-1:0]   grn6;
    logic [B565_W-1:0]   blu5;
    rgb888_t             rgb_wide;

    assign pix_arr[0] = pix1_i;
    assign pix_arr[1] = pix2_i;
    assign valid_vec  = {valid2_i, valid1_i};
    assign vsync_vec  = {vsync2_i, vsync1_i};

    assign pix_sel = pix_arr[sel_i];

    assign red5 = pix_sel[R565_LSB +: R565_W];
    assign grn6 = pix_sel[G565_LSB +: G565_W];
    assign blu5 = pix_sel[B565_LSB +: B565_W];

    // msb replication so full scale maps to 8'hff
    assign rgb_wide = {red5, red5[R565_W-1 -: LANE888_W-R565_W],
                       grn6, grn6[G565_W-1 -: LANE888_W-G565_W],
                       blu5, blu5[B565_W-1 -: LANE888_W-B565_W]};

    // display side output registers
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            de_o <= 1'b0;
            vs_o <= 1'b0;
        end else begin
            de_o <= valid_vec[sel_i];
            vs_o <= vsync_vec[sel_i];
        end
    end

    always_ff @(posedge core_clk) begin
        rgb_o <= rgb_wide;
    end

endmodule

// ==== rtl/heartbeat_led.sv ====
`timescale 1ns/10ps

module heartbeat_led
    import board_pkg::*;
(
    input  logic core_clk,
    input  logic rst_i,
    input  logic run_i,       // cameras released
    output logic led_o
);

    logic [HB_CNT_W-1:0] hb_cnt;
    logic                hb_wrap;

    assign hb_wrap = (hb_cnt == HB_CNT_W'(HEARTBEAT_CYCLES));

    // period counter, wraps on the threshold itself
    always_ff @(posedge core_clk) begin
        if (rst_i || !run_i) begin
            hb_cnt <= '0;
        end else if (hb_wrap) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst_i || !run_i) begin
            led_o <= 1'b1;        // lit while waiting for the cameras
        end else if (hb_wrap) begin
            led_o <= ~led_o;
        end
    end

endmodule

// ==== rtl/video_capture_top.sv ====
`timescale 1ns/10ps

module video_capture_top
    import video_pkg::*;
(
    input  logic      core_clk,
    input  logic      rst_i,
    // camera 1
    input  cam_byte_t cam1_data_i,
    input  logic      cam1_href_i,
    input  logic      cam1_vsync_i,
    // camera 2
    input  cam_byte_t cam2_data_i,
    input  logic      cam2_href_i,
    input  logic      cam2_vsync_i,
    input  logic      sel_i,          // display source select
    output logic      cam_rstn_o,     // shared sensor reset
    // video out
    output rgb888_t   rgb_o,
    output logic      de_o,
    output logic      vs_o,
    output logic      led_o           // status heartbeat
);

    rgb565_t pix1;
    rgb565_t pix2;
    logic    valid1;
    logic    valid2;
    logic    vsync1;
    logic    vsync2;

    power_on_reset u_por (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .cam_rstn_o (cam_rstn_o)
    );

    cmos_pixel_pack u_cam1_pack (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .cam_rstn_i  (cam_rstn_o),
        .cam_data_i  (cam1_data_i),
        .cam_href_i  (cam1_href_i),
        .cam_vsync_i (cam1_vsync_i),
        .pix_o       (pix1),
        .pix_valid_o (valid1),
        .vsync_o     (vsync1)
    );

    cmos_pixel_pack u_cam2_pack (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .cam_rstn_i  (cam_rstn_o),
        .cam_data_i  (cam2_data_i),
        .cam_href_i  (cam2_href_i),
        .cam_vsync_i (cam2_vsync_i),
        .pix_o       (pix2),
        .pix_valid_o (valid2),
        .vsync_o     (vsync2)
    );

    video_out_mux u_out_mux (
        .core_clk (core_clk),
        .rst_i    (rst_i),
        .sel_i    (sel_i),
        .pix1_i   (pix1),
        .pix2_i   (pix2),
        .valid1_i (valid1),
        .valid2_i (valid2),
        .vsync1_i (vsync1),
        .vsync2_i (vsync2),
        .rgb_o    (rgb_o),
        .de_o     (de_o),
        .vs_o     (vs_o)
    );

    // led starts blinking once the sensors leave reset
    heartbeat_led u_heartbeat (
        .core_clk (core_clk),
        .rst_i    (rst_i),
        .run_i    (cam_rstn_o),
        .led_o    (led_o)
    );

endmodule

// ==== testbench/tb_video_capture.sv ====
`timescale 1ns/10ps

module tb_video_capture
    import board_pkg::*;
    import video_pkg::*;
;

    logic      core_clk = 1'b0;
    logic      rst_i;
    cam_byte_t cam1_data_i;
    logic      cam1_href_i;
    logic      cam1_vsync_i;
    cam_byte_t cam2_data_i;
    logic      cam2_href_i;
    logic      cam2_vsync_i;
    logic      sel_i;
    logic      cam_rstn_o;
    rgb888_t   rgb_o;
    logic      de_o;
    logic      vs_o;
    logic      led_o;

    int      errors    = 0;
    int      cyc       = 0;    // rising edges seen so far
    int      first_low = 0;    // first edge with rst_i low
    int      rstn_edge = 0;
    bit      rstn_seen = 1'b0;
    logic    led_prev  = 1'b1;
    int      de_edges[$];
    rgb888_t de_data[$];
    int      vs_edges[$];
    int      led_edges[$];

    video_capture_top u_dut (
        .core_clk     (core_clk),
        .rst_i        (rst_i),
        .cam1_data_i  (cam1_data_i),
        .cam1_href_i  (cam1_href_i),
        .cam1_vsync_i (cam1_vsync_i),
        .cam2_data_i  (cam2_data_i),
        .cam2_href_i  (cam2_href_i),
        .cam2_vsync_i (cam2_vsync_i),
        .sel_i        (sel_i),
        .cam_rstn_o   (cam_rstn_o),
        .rgb_o        (rgb_o),
        .de_o         (de_o),
        .vs_o         (vs_o),
        .led_o        (led_o)
    );

    always #5 core_clk = ~core_clk;

    always @(posedge core_clk) begin
        cyc <= cyc + 1;
        if (!rst_i && first_low == 0) begin
            first_low <= cyc + 1;
        end
    end

    // outputs are sampled mid cycle, tagged with the edge that produced them
    always @(negedge core_clk) begin
        if (de_o) begin
            de_edges.push_back(cyc);
            de_data.push_back(rgb_o);
        end
        if (vs_o) begin
            vs_edges.push_back(cyc);
        end
        if (cam_rstn_o && !rstn_seen) begin
            rstn_seen = 1'b1;
            rstn_edge = cyc;
        end
        if (rstn_seen && led_o != led_prev) begin
            led_edges.push_back(cyc);
        end
        led_prev = led_o;
    end

    // field reversal then msb repetition into each 8-bit lane
    function automatic rgb888_t expand_pixel(input cam_byte_t hi, input cam_byte_t lo);
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        r5 = lo[4:0];
        g6 = {hi[2:0], lo[7:5]};
        b5 = hi[7:3];
        return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic run_line(input string name, input logic sel,
                            input cam_byte_t a0, input cam_byte_t a1,
                            input cam_byte_t a2, input cam_byte_t a3,
                            input cam_byte_t b0, input cam_byte_t b1,
                            input cam_byte_t b2, input cam_byte_t b3,
                            input rgb888_t e0, input rgb888_t e1);
        int low_edge[2];
        int gap;
        int wait_cnt;
        check_value({name, " file cross-check 0"}, sel ? expand_pixel(b0, b1)
                    : expand_pixel(a0, a1), e0);
        check_value({name, " file cross-check 1"}, sel ? expand_pixel(b2, b3)
                    : expand_pixel(a2, a3), e1);
        de_edges.delete();
        de_data.delete();
        @(posedge core_clk);
        sel_i       <= sel;
        cam1_href_i <= 1'b1;
        cam2_href_i <= 1'b1;
        cam1_data_i <= a0;
        cam2_data_i <= b0;
        @(posedge core_clk);
        cam1_data_i <= a1;
        cam2_data_i <= b1;
        low_edge[0] = cyc + 4;     // driven at edge cyc+1, de three edges on
        @(posedge core_clk);
        cam1_data_i <= a2;
        cam2_data_i <= b2;
        @(posedge core_clk);
        cam1_data_i <= a3;
        cam2_data_i <= b3;
        low_edge[1] = cyc + 4;
        @(posedge core_clk);
        cam1_href_i <= 1'b0;
        cam2_href_i <= 1'b0;
        cam1_data_i <= '0;
        cam2_data_i <= '0;
        gap = 1 + ($urandom % 8);
        repeat (gap) @(posedge core_clk);
        wait_cnt = 0;
        while (de_edges.size() < 2 && wait_cnt < 20) begin
            @(posedge core_clk);
            wait_cnt++;
        end
        repeat (4) @(posedge core_clk);
        if (de_edges.size() != 2) begin
            $display("%s: expected two de_o pulses but saw %0d", name, de_edges.size());
            errors++;
        end else begin
            check_value({name, " de edge 0"}, low_edge[0], de_edges[0]);
            check_value({name, " de edge 1"}, low_edge[1], de_edges[1]);
            check_value({name, " rgb 0"}, e0, de_data[0]);
            check_value({name, " rgb 1"}, e1, de_data[1]);
        end
    endtask

    task automatic read_stimulus();
        int        fd;
        int        n;
        int        ln;
        int        sel;
        string     line;
        cam_byte_t a0, a1, a2, a3, b0, b1, b2, b3;
        rgb888_t   e0, e1;
        ln = 0;
        fd = $fopen("testbench/stim_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";               // a read at end of file leaves the old text behind
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        sel, a0, a1, a2, a3, b0, b1, b2, b3, e0, e1);
            if (n == 11) begin      // comment and blank lines fall through
                ln++;
                run_line($sformatf("pixel_path line %0d", ln), sel[0],
                         a0, a1, a2, a3, b0, b1, b2, b3, e0, e1);
            end
        end
        $fclose(fd);
        if (ln == 0) begin
            $display("the stimulus file held no pixel lines");
            errors++;
        end
    endtask

    task automatic odd_byte_drop();
        int low_edge[2];
        int wait_cnt;
        de_edges.delete();
        de_data.delete();
        @(posedge core_clk);
        sel_i       <= 1'b0;
        cam1_href_i <= 1'b1;
        cam1_data_i <= 8'h12;
        @(posedge core_clk);
        cam1_data_i <= 8'h34;
        low_edge[0] = cyc + 4;
        @(posedge core_clk);
        cam1_data_i <= 8'hff;      // stray third byte
        @(posedge core_clk);
        cam1_href_i <= 1'b0;
        cam1_data_i <= '0;
        @(posedge core_clk);
        cam1_href_i <= 1'b1;
        cam1_data_i <= 8'hab;
        @(posedge core_clk);
        cam1_data_i <= 8'hcd;
        low_edge[1] = cyc + 4;
        @(posedge core_clk);
        cam1_href_i <= 1'b0;
        cam1_data_i <= '0;
        wait_cnt = 0;
        while (de_edges.size() < 2 && wait_cnt < 20) begin
            @(posedge core_clk);
            wait_cnt++;
        end
        repeat (6) @(posedge core_clk);
        if (de_edges.size() != 2) begin
            $display("odd_byte_drop: expected two de_o pulses but saw %0d", de_edges.size());
            errors++;
        end else begin
            check_value("odd_byte_drop de edge 0", low_edge[0], de_edges[0]);
            check_value("odd_byte_drop de edge 1", low_edge[1], de_edges[1]);
            check_value("odd_byte_drop rgb 0", expand_pixel(8'h12, 8'h34), de_data[0]);
            check_value("odd_byte_drop rgb 1", expand_pixel(8'hab, 8'hcd), de_data[1]);
        end
    endtask

    task automatic vsync_path(input logic sel);
        int exp_edge;
        int wait_cnt;
        vs_edges.delete();
        @(posedge core_clk);
        sel_i <= sel;
        if (sel) begin
            cam2_vsync_i <= 1'b1;
        end else begin
            cam1_vsync_i <= 1'b1;
        end
        exp_edge = cyc + 3;
        @(posedge core_clk);
        cam1_vsync_i <= 1'b0;
        cam2_vsync_i <= 1'b0;
        wait_cnt = 0;
        while (vs_edges.size() < 1 && wait_cnt < 10) begin
            @(posedge core_clk);
            wait_cnt++;
        end
        repeat (3) @(posedge core_clk);
        if (vs_edges.size() != 1) begin
            $display("vsync_path sel %0d: the selected vsync pulse did not show once on vs_o",
                     sel);
            errors++;
        end else begin
            check_value($sformatf("vsync_path sel %0d vs edge", sel), exp_edge, vs_edges[0]);
        end
        vs_edges.delete();
        @(posedge core_clk);
        if (sel) begin
            cam1_vsync_i <= 1'b1;
        end else begin
            cam2_vsync_i <= 1'b1;
        end
        @(posedge core_clk);
        cam1_vsync_i <= 1'b0;
        cam2_vsync_i <= 1'b0;
        repeat (6) @(posedge core_clk);   // fixed window, pulse must stay hidden
        if (vs_edges.size() != 0) begin
            $display("vsync_path sel %0d: vs_o followed the unselected camera's vsync", sel);
            errors++;
        end
    endtask

    initial begin
        int wait_cnt;
        rst_i        = 1'b1;
        cam1_data_i  = '0;
        cam1_href_i  = 1'b0;
        cam1_vsync_i = 1'b0;
        cam2_data_i  = '0;
        cam2_href_i  = 1'b0;
        cam2_vsync_i = 1'b0;
        sel_i        = 1'b0;
        void'($urandom(32'hd82af872));
        repeat (2) @(posedge core_clk);
        rst_i <= 1'b0;
        @(negedge core_clk);
        check_value("reset_state cam_rstn_o", 1'b0, cam_rstn_o);
        check_value("reset_state de_o", 1'b0, de_o);
        check_value("reset_state vs_o", 1'b0, vs_o);
        check_value("reset_state led_o", 1'b1, led_o);

        wait_cnt = 0;
        while (!rstn_seen && wait_cnt < 12000) begin
            @(posedge core_clk);
            wait_cnt++;
        end
        if (!rstn_seen) begin
            $display("cam_rstn_o never went high after reset");
            errors++;
        end else begin
            check_value("reset_release edge", first_low + int'(RESET_HOLD_CYCLES), rstn_edge);
        end

        read_stimulus();
        odd_byte_drop();
        vsync_path(1'b0);
        vsync_path(1'b1);

        wait_cnt = 0;
        while (led_edges.size() < 3 && wait_cnt < 8000) begin
            @(posedge core_clk);
            wait_cnt++;
        end
        if (led_edges.size() < 3) begin
            $display("led_o did not toggle three times after the camera reset release");
            errors++;
        end else begin
            check_value("heartbeat first toggle", rstn_edge + int'(HEARTBEAT_CYCLES) + 1,
                        led_edges[0]);
            check_value("heartbeat period 1", int'(HEARTBEAT_CYCLES) + 1,
                        led_edges[1] - led_edges[0]);
            check_value("heartbeat period 2", int'(HEARTBEAT_CYCLES) + 1,
                        led_edges[2] - led_edges[1]);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/stim_input.txt ====
# sel cam1_b0 cam1_b1 cam1_b2 cam1_b3 cam2_b0 cam2_b1 cam2_b2 cam2_b3 exp_rgb0 exp_rgb1
# bytes in href order, high byte first; expected rgb888 for the selected camera
0 ff ff 00 00 12 34 ab cd ffffff 000000
1 ff ff 00 00 12 34 ab cd a54510 6b79ad
0 f8 00 00 1f 07 e0 80 01 0000ff ff0000
1 f8 00 00 1f 07 e0 80 01 00ff00 080084
0 5a a5 c3 3c 01 23 fe dc 29555a e765c6
1 5a a5 c3 3c 01 23 fe dc 182400 e7dbff
0 10 80 aa 55 12 34 5a a5 001010 ad49ad
1 10 80 aa 55 12 34 5a a5 a54510 29555a
0 ab cd 01 23 c3 3c 10 80 6b79ad 182400
1 ab cd 01 23 c3 3c 10 80 e765c6 001010
0 07 e0 fe dc aa 55 f8 00 00ff00 e7dbff
1 07 e0 fe dc aa 55 f8 00 ad49ad 0000ff

// ==== sim.f ====
rtl/board_pkg.sv
rtl/video_pkg.sv
rtl/power_on_reset.sv
rtl/cmos_pixel_pack.sv
rtl/video_out_mux.sv
rtl/heartbeat_led.sv
rtl/video_capture_top.sv
testbench/tb_video_capture.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module tb_video_capture -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
